//--- rtl/ring_pkg.sv
// ====================
// Shared sizes and types for the message ring writer
// Line, address and ring index widths
// Idle counter width for the idle flush
// Flush-control state encoding
// ====================

`default_nettype none

package ring_pkg;

    // ====================
    // Sizes
    // ====================

    // Width of one data line written to the ring
    localparam int unsigned LINE_W = 64;

    // Width of a host memory line address
    localparam int unsigned ADDR_W = 32;

    // Width of a ring index, giving a ring of 64 slots
    // All ring arithmetic wraps modulo 2**IDX_W
    localparam int unsigned IDX_W = 6;

    // Width of the idle counter
    // The top bit sets after 16 idle cycles and requests a flush
    localparam int unsigned IDLE_W = 5;

    // ====================
    // Types
    // ====================

    typedef logic [LINE_W-1:0] line_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IDX_W-1:0]  idx_t;

    // WAIT_EMPTY has nothing unpublished, WAIT_DATA has lines written
    // but not yet fenced, EMIT_FENCE is sending the fence
    typedef enum logic [1:0] {
        WAIT_EMPTY,
        WAIT_DATA,
        EMIT_FENCE
    } flush_state_t;

endpackage

`default_nettype wire

//--- rtl/line_fifo.sv
// ====================
// Two-entry registered buffer with valid/ready on both sides
// The payload type is a parameter
// ====================

`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_deq
);

    // Storage for the two entries
    payload_t entry [2];

    // Write and read slots, and the number of entries held
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    logic enq;
    logic deq;

    // Input is refused only when both entries are held
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];

    assign enq = in_valid && in_ready;
    assign deq = out_deq && out_valid;

    // Payload storage, written on each accepted input
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            entry[wr_ptr] <= in_data;
        end
    end

    // Slot pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (enq)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (deq)
            begin
                rd_ptr <= ~rd_ptr;
            end
            // Simultaneous enqueue and dequeue leave the count as it is
            case ({enq, deq})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/idle_timer.sv
// ====================
// Idle timer for the ring writer
// Counts idle channel cycles while unfenced lines are pending
// Raises and holds the idle-flush request
// ====================

`timescale 1ns/1ps
`default_nettype none

module idle_timer (
    input  logic                   clk,
    input  logic                   reset_n,
    input  ring_pkg::flush_state_t state,
    input  logic                   line_deq,
    input  logic                   req_ready,
    output logic                   flush_idle
);

    logic [ring_pkg::IDLE_W-1:0] idle_count;
    logic                        idle_hold;
    logic                        idle_seen;

    // Idle limit reached now or earlier and not yet served by a fence
    assign idle_seen = idle_count[ring_pkg::IDLE_W-1] || idle_hold;

    // The request reaches the FSM only in a cycle where the channel accepts,
    // so a line offered in that same cycle is taken before the fence starts
    assign flush_idle = idle_seen && req_ready;

    // Count only while writes are pending, nothing moves and the channel
    // could take a request; any other cycle restarts the count
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            idle_count <= '0;
        end
        else if ((state == ring_pkg::WAIT_DATA) && !line_deq && req_ready)
        begin
            idle_count <= idle_count + 1'b1;
        end
        else
        begin
            idle_count <= '0;
        end
    end

    // Keep the request alive until the fence state is reached
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            idle_hold <= 1'b0;
        end
        else
        begin
            idle_hold <= idle_seen && (state != ring_pkg::EMIT_FENCE);
        end
    end

endmodule

`default_nettype wire

//--- rtl/flush_fsm.sv
// ====================
// Flush control for the ring writer
// Keeps the write index and the published index
// Decides when a fence is due, on a quarter-ring crossing or on idle
// ====================

`timescale 1ns/1ps
`default_nettype none

module flush_fsm (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   issued,
    input  logic                   flush_idle,
    output ring_pkg::flush_state_t state,
    output ring_pkg::idx_t         cur_idx,
    output ring_pkg::idx_t         written_idx,
    output logic                   fence_due
);

    ring_pkg::flush_state_t next_state;

    // Set once the write index has moved into another quarter of the
    // ring than the published index
    logic flush_writes;

    // An accepted request is a line outside the fence state
    logic line_issued;
    logic fence_issued;

    assign flush_writes = (cur_idx[ring_pkg::IDX_W-2] != written_idx[ring_pkg::IDX_W-2]);

    assign fence_due    = (state == ring_pkg::EMIT_FENCE);
    assign line_issued  = issued && !fence_due;
    assign fence_issued = issued && fence_due;

    // ====================
    // State transitions
    // ====================

    always_comb
    begin
        next_state = state;
        case (state)
            ring_pkg::WAIT_EMPTY:
            begin
                // The first line after a fence opens a new batch
                if (line_issued)
                begin
                    next_state = ring_pkg::WAIT_DATA;
                end
            end

            ring_pkg::WAIT_DATA:
            begin
                // Time to make the batch visible to the host
                if (flush_idle || flush_writes)
                begin
                    next_state = ring_pkg::EMIT_FENCE;
                end
            end

            ring_pkg::EMIT_FENCE:
            begin
                if (fence_issued)
                begin
                    next_state = ring_pkg::WAIT_EMPTY;
                end
            end

            default:
            begin
                next_state = ring_pkg::WAIT_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ring_pkg::WAIT_EMPTY;
        end
        else
        begin
            state <= next_state;
        end
    end

    // ====================
    // Ring indices
    // ====================

    // Next slot to write, one step per accepted line
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cur_idx <= '0;
        end
        else if (line_issued)
        begin
            cur_idx <= cur_idx + ring_pkg::idx_t'(1);
        end
    end

    // Published index, which covers every line written before the fence
    // No line is accepted in the fence state, so cur_idx is stable here
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            written_idx <= '0;
        end
        else if (fence_issued)
        begin
            written_idx <= cur_idx;
        end
    end

endmodule

`default_nettype wire

//--- rtl/write_req_gen.sv
// ====================
// Memory request generator for the ring writer
// Forms line and fence requests and checks ring space
// Reports every accepted request
// ====================

`timescale 1ns/1ps
`default_nettype none

module write_req_gen (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            enable,
    input  ring_pkg::addr_t base_addr,
    input  ring_pkg::idx_t  oldest_idx,
    input  ring_pkg::idx_t  cur_idx,
    input  logic            fence_due,
    input  logic            line_valid,
    input  ring_pkg::line_t line_data,
    output logic            line_deq,
    output logic            req_valid,
    output logic            req_fence,
    output ring_pkg::addr_t req_addr,
    output ring_pkg::line_t req_data,
    input  logic            req_ready,
    output logic            issued
);

    // Quarter bit of the write index as it was last cycle
    logic quarter_q;
    logic quarter_step;

    logic has_space;
    logic line_ok;

    // The write index just entered a new quarter, so the FSM switches to
    // the fence next cycle; a line offered now could be stalled and then
    // replaced by the fence, so no line is offered in this cycle
    assign quarter_step = (cur_idx[ring_pkg::IDX_W-2] != quarter_q);

    // The next slot must not reach the oldest unconsumed entry
    assign has_space = ((cur_idx + ring_pkg::idx_t'(1)) != oldest_idx);

    assign line_ok = line_valid && !fence_due && !quarter_step;

    // Combinational from the inputs
    assign req_valid = enable && has_space && (line_ok || fence_due);
    assign req_fence = fence_due;

    // A fence carries address zero and no payload
    assign req_addr = fence_due ? '0 : (base_addr + ring_pkg::addr_t'(cur_idx));
    assign req_data = fence_due ? '0 : line_data;

    assign issued   = req_valid && req_ready;
    assign line_deq = issued && !fence_due;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            quarter_q <= 1'b0;
        end
        else
        begin
            quarter_q <= cur_idx[ring_pkg::IDX_W-2];
        end
    end

endmodule

`default_nettype wire

//--- rtl/ring_writer_top.sv
// ====================
// Top level of the device-to-host message ring writer
// Line FIFO, idle timer, flush FSM and request generator
// ====================

`timescale 1ns/1ps
`default_nettype none

module ring_writer_top (
    input  logic            clk,
    input  logic            reset_n,

    // Producer side
    input  ring_pkg::line_t tx_data,
    input  logic            tx_valid,
    output logic            tx_ready,

    // Host control and status
    input  logic            enable,
    input  ring_pkg::addr_t base_addr,
    input  ring_pkg::idx_t  oldest_idx,
    output ring_pkg::idx_t  written_idx,

    // Memory request channel
    output logic            req_valid,
    output logic            req_fence,
    output ring_pkg::addr_t req_addr,
    output ring_pkg::line_t req_data,
    input  logic            req_ready
);

    // FIFO head towards the request generator
    logic            line_valid;
    ring_pkg::line_t line_data;
    logic            line_deq;

    // Flush control towards the generator and the timer
    ring_pkg::flush_state_t state;
    ring_pkg::idx_t         cur_idx;
    logic                   fence_due;

    logic issued;
    logic flush_idle;

    // ====================
    // Line buffering
    // ====================

    line_fifo #(
        .payload_t (ring_pkg::line_t)
    ) line_fifo_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_data   (tx_data),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_data  (line_data),
        .out_valid (line_valid),
        .out_deq   (line_deq)
    );

    // ====================
    // Flush decision
    // ====================

    idle_timer idle_timer_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .state      (state),
        .line_deq   (line_deq),
        .req_ready  (req_ready),
        .flush_idle (flush_idle)
    );

    flush_fsm flush_fsm_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .issued      (issued),
        .flush_idle  (flush_idle),
        .state       (state),
        .cur_idx     (cur_idx),
        .written_idx (written_idx),
        .fence_due   (fence_due)
    );

    // ====================
    // Request generation
    // ====================

    write_req_gen write_req_gen_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable     (enable),
        .base_addr  (base_addr),
        .oldest_idx (oldest_idx),
        .cur_idx    (cur_idx),
        .fence_due  (fence_due),
        .line_valid (line_valid),
        .line_data  (line_data),
        .line_deq   (line_deq),
        .req_valid  (req_valid),
        .req_fence  (req_fence),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .req_ready  (req_ready),
        .issued     (issued)
    );

endmodule

`default_nettype wire

//--- test/ring_writer_asserts.sv
// ====================
// Concurrent assertions for the ring writer top level
// Held request stability, ring full and fence ordering
// Attached to ring_writer_top with bind
// ====================

`timescale 1ns/1ps
`default_nettype none

module ring_writer_asserts (
    input logic            clk,
    input logic            reset_n,
    input logic            enable,
    input logic            req_valid,
    input logic            req_fence,
    input logic            req_ready,
    input ring_pkg::addr_t req_addr,
    input ring_pkg::line_t req_data,
    input ring_pkg::idx_t  oldest_idx,
    input ring_pkg::idx_t  written_idx
);

    // Number of assertion failures
    int fail_count = 0;

    // Slot of the next line, counted from the line requests taken so far
    ring_pkg::idx_t line_slot;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            line_slot <= '0;
        end
        else if (req_valid && req_ready && !req_fence)
        begin
            line_slot <= line_slot + ring_pkg::idx_t'(1);
        end
    end

    // A stalled request keeps its contents until taken, unless enable drops
    held_request_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (enable && req_valid && !req_ready) |=>
        (!enable || (req_valid && $stable(req_fence) && $stable(req_addr) && $stable(req_data))))
    else
    begin
        fail_count = fail_count + 1;
        $error("held memory request changed before it was accepted");
    end

    // The next slot may never reach the host's oldest unconsumed entry
    no_line_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        (req_valid && !req_fence) |-> (ring_pkg::idx_t'(line_slot + 1'b1) != oldest_idx))
    else
    begin
        fail_count = fail_count + 1;
        $error("line request made while the ring is full");
    end

    // The published index moves only in the cycle after an accepted fence
    published_after_fence: assert property (@(posedge clk) disable iff (!reset_n)
        !$stable(written_idx) |-> $past(req_valid && req_ready && req_fence))
    else
    begin
        fail_count = fail_count + 1;
        $error("written_idx moved without a fence");
    end

endmodule

bind ring_writer_top ring_writer_asserts ring_writer_asserts_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .enable      (enable),
    .req_valid   (req_valid),
    .req_fence   (req_fence),
    .req_ready   (req_ready),
    .req_addr    (req_addr),
    .req_data    (req_data),
    .oldest_idx  (oldest_idx),
    .written_idx (written_idx)
);

`default_nettype wire

//--- test/ring_writer_checker.sv
// ====================
// Scoreboard for the ring writer
// Keeps the producer's lines in order and checks each memory request
// Checks the published index after fences and the fence spacing
// Prints one line per case
// ====================

`timescale 1ns/1ps
`default_nettype none

module ring_writer_checker (
    input  logic            clk,
    input  logic            reset_n,
    input  ring_pkg::line_t tx_data,
    input  logic            tx_valid,
    input  logic            tx_ready,
    input  logic            enable,
    input  ring_pkg::addr_t base_addr,
    input  ring_pkg::idx_t  oldest_idx,
    input  ring_pkg::idx_t  written_idx,
    input  logic            req_valid,
    input  logic            req_fence,
    input  ring_pkg::addr_t req_addr,
    input  ring_pkg::line_t req_data,
    input  logic            req_ready,
    input  logic            case_done,
    input  int              case_num,
    output logic            drained,
    output int              error_count,
    output int              failed_cases
);

    // A batch is never larger than a quarter of the ring plus one line
    localparam int MAX_BATCH = 17;
    // Enabled cycles without any accepted request while lines wait for a fence
    localparam int FENCE_WAIT = 400;

    ring_pkg::line_t expect_q [$];
    ring_pkg::line_t exp_data;
    ring_pkg::idx_t  slot;

    int   line_count;
    int   since_fence;
    int   stall_cycles;
    int   case_errors;
    int   case_lines;
    logic fence_check;
    logic reset_checked;

    initial
    begin
        line_count    = 0;
        since_fence   = 0;
        stall_cycles  = 0;
        case_errors   = 0;
        case_lines    = 0;
        fence_check   = 1'b0;
        reset_checked = 1'b0;
        error_count   = 0;
        failed_cases  = 0;
        drained       = 1'b1;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        begin
            if (got !== expected)
            begin
                $display("FAILED %s: got %0h, expected %0h at %0t", name, got, expected, $time);
                error_count = error_count + 1;
                case_errors = case_errors + 1;
            end
        end
    endtask

    task automatic flag_problem(input string what);
        begin
            $display("Error at %0t: %s", $time, what);
            error_count = error_count + 1;
            case_errors = case_errors + 1;
        end
    endtask

    // ====================
    // Sampling
    // ====================

    // All signals are sampled at the falling edge, where they are settled
    always @(negedge clk)
    begin
        if (reset_n && !reset_checked)
        begin
            // Idle state straight after reset
            reset_checked = 1'b1;
            check_value("req_valid", req_valid, 1'b0);
            check_value("written_idx", written_idx, 6'd0);
            check_value("tx_ready", tx_ready, 1'b1);
        end
        if (reset_n)
        begin
            // The fence accepted last cycle publishes every line before it
            if (fence_check)
            begin
                check_value("written_idx", written_idx, ring_pkg::idx_t'(line_count));
                fence_check = 1'b0;
            end
            if (req_valid && !enable)
            begin
                flag_problem("request raised while enable is low");
            end
            if (req_valid && req_ready)
            begin
                stall_cycles = 0;
                if (req_fence)
                begin
                    check_value("req_addr", req_addr, 32'h0);
                    since_fence = 0;
                    fence_check = 1'b1;
                end
                else
                begin
                    slot = ring_pkg::idx_t'(line_count);
                    if (expect_q.size() == 0)
                    begin
                        flag_problem("line request with no line sent by the producer");
                    end
                    else
                    begin
                        exp_data = expect_q.pop_front();
                        check_value("req_data", req_data, exp_data);
                    end
                    check_value("req_addr", req_addr, base_addr + ring_pkg::addr_t'(slot));
                    if (ring_pkg::idx_t'(slot + 1'b1) == oldest_idx)
                    begin
                        flag_problem("line written into the slot before the oldest entry");
                    end
                    line_count  = line_count + 1;
                    case_lines  = case_lines + 1;
                    since_fence = since_fence + 1;
                    if (since_fence == MAX_BATCH + 1)
                    begin
                        flag_problem("more than 17 lines accepted without a fence");
                    end
                end
            end
            else if (enable && (since_fence > 0))
            begin
                stall_cycles = stall_cycles + 1;
                if (stall_cycles == FENCE_WAIT)
                begin
                    flag_problem("lines waited 400 enabled cycles without a fence");
                end
            end
            if (tx_valid && tx_ready)
            begin
                expect_q.push_back(tx_data);
            end
            if (case_done)
            begin
                $display("case %0d: %0d lines, %0d errors, %s", case_num, case_lines,
                         case_errors, (case_errors == 0) ? "pass" : "fail");
                if (case_errors != 0)
                begin
                    failed_cases = failed_cases + 1;
                end
                case_errors = 0;
                case_lines  = 0;
            end
            drained = (expect_q.size() == 0) && (since_fence == 0) && !fence_check;
        end
    end

endmodule

`default_nettype wire

//--- test/ring_writer_tb.sv
// ====================
// Testbench for the message ring writer
// Clock, reset, DUT, producer and host models
// Reads the cases, enforces the timeout, prints the summary
// ====================

`timescale 1ns/1ps
`default_nettype none

module ring_writer_tb;

    localparam time             HALF_PERIOD    = 50ns;
    localparam int              MAX_CASES      = 32;
    localparam int              FIELDS         = 5;
    localparam int              TIMEOUT_MARGIN = 2000;
    localparam int              RELEASE_RUN    = 20;
    localparam ring_pkg::addr_t RING_BASE      = 32'h0004_0000;

    logic            clk;
    logic            reset_n;
    ring_pkg::line_t tx_data;
    logic            tx_valid;
    logic            tx_ready;
    logic            enable;
    ring_pkg::addr_t base_addr;
    ring_pkg::idx_t  oldest_idx;
    ring_pkg::idx_t  written_idx;
    logic            req_valid;
    logic            req_fence;
    ring_pkg::addr_t req_addr;
    ring_pkg::line_t req_data;
    logic            req_ready;

    logic case_done;
    int   case_num;
    logic drained;
    int   error_count;
    int   failed_cases;

    // Each case holds five words for the count, gap, consume period,
    // enable pattern and data seed
    logic [31:0] case_mem [0:MAX_CASES*FIELDS-1];

    int          seed;
    int          data_seed;
    int          num_cases;
    int          cycle_count = 0;
    int          cycle_limit;
    int          case_start;
    int          consume_rate;
    logic [31:0] enable_pattern;
    int          host_case;
    int          blocked_run;
    logic        host_released;
    logic        consume;
    int          total_errors;
    int          c;

    always
    begin
        #(HALF_PERIOD) clk = ~clk;
    end

    ring_writer_top ring_writer_top_i (
        .clk (clk), .reset_n (reset_n),
        .tx_data (tx_data), .tx_valid (tx_valid), .tx_ready (tx_ready),
        .enable (enable), .base_addr (base_addr),
        .oldest_idx (oldest_idx), .written_idx (written_idx),
        .req_valid (req_valid), .req_fence (req_fence), .req_addr (req_addr),
        .req_data (req_data), .req_ready (req_ready)
    );

    ring_writer_checker ring_writer_checker_i (
        .clk (clk), .reset_n (reset_n),
        .tx_data (tx_data), .tx_valid (tx_valid), .tx_ready (tx_ready),
        .enable (enable), .base_addr (base_addr),
        .oldest_idx (oldest_idx), .written_idx (written_idx),
        .req_valid (req_valid), .req_fence (req_fence), .req_addr (req_addr),
        .req_data (req_data), .req_ready (req_ready),
        .case_done (case_done), .case_num (case_num), .drained (drained),
        .error_count (error_count), .failed_cases (failed_cases)
    );

    // Run limit from the length of the cases
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ====================
    // Host and memory channel
    // ====================

    // Random channel stalls, the enable pattern and consumption up to the
    // published index; a consume period of 0 holds the host until the
    // producer has been blocked for a while
    always @(posedge clk)
    begin
        #1;
        if (reset_n)
        begin
            if (host_case != case_num)
            begin
                host_case     = case_num;
                host_released = 1'b0;
                blocked_run   = 0;
            end
            req_ready   = (($random(seed) & 15) != 0);
            enable      = enable_pattern[((cycle_count - case_start) >> 4) & 31];
            blocked_run = tx_ready ? 0 : blocked_run + 1;
            if (blocked_run >= RELEASE_RUN)
            begin
                host_released = 1'b1;
            end
            if (consume_rate == 0)
                consume = host_released;
            else
                consume = (((cycle_count - case_start) % consume_rate) == 0);
            if (consume && (oldest_idx != written_idx))
            begin
                oldest_idx = oldest_idx + 1'b1;
            end
        end
    end

    // ====================
    // Producer
    // ====================

    // Holds the line until the FIFO takes it, as seen at the falling edge
    task automatic send_line;
        logic took;
        begin
            took = 1'b0;
            while (!took)
            begin
                @(negedge clk);
                took = tx_ready;
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic run_case(input int index);
        int lines;
        int gap;
        int n;
        begin
            @(negedge clk);
            lines          = case_mem[index*FIELDS];
            gap            = case_mem[index*FIELDS+1];
            consume_rate   = case_mem[index*FIELDS+2];
            enable_pattern = case_mem[index*FIELDS+3];
            data_seed      = case_mem[index*FIELDS+4];
            case_start     = cycle_count;
            case_num       = index;
            @(posedge clk);
            #1;
            for (n = 0; n < lines; n++)
            begin
                tx_data  = {$random(data_seed), $random(data_seed)};
                tx_valid = 1'b1;
                send_line();
                tx_valid = 1'b0;
                repeat (gap)
                begin
                    @(posedge clk);
                    #1;
                end
            end
            // Every line written and fenced before the case closes
            do
                @(posedge clk);
            while (!drained);
            #1 case_done = 1'b1;
            @(posedge clk);
            #1 case_done = 1'b0;
        end
    endtask

    initial
    begin
        clk            = 1'b0;
        reset_n        = 1'b0;
        tx_data        = '0;
        tx_valid       = 1'b0;
        enable         = 1'b1;
        base_addr      = RING_BASE;
        oldest_idx     = '0;
        req_ready      = 1'b1;
        case_done      = 1'b0;
        case_num       = 0;
        seed           = 32'h7e5c_1f3d;
        case_start     = 0;
        consume_rate   = 1;
        enable_pattern = '1;
        host_case      = -1;
        blocked_run    = 0;
        host_released  = 1'b0;
        for (c = 0; c < MAX_CASES*FIELDS; c++)
        begin
            case_mem[c] = '0;
        end
        $readmemh("test/ring_writer_cases.txt", case_mem);

        // A case with no lines ends the list
        num_cases   = 0;
        cycle_limit = TIMEOUT_MARGIN + 20;
        while ((num_cases < MAX_CASES) && (case_mem[num_cases*FIELDS] != 0))
        begin
            cycle_limit = cycle_limit
                + case_mem[num_cases*FIELDS] * (case_mem[num_cases*FIELDS+1] + 40);
            num_cases   = num_cases + 1;
        end

        repeat (10) @(posedge clk);
        #1 reset_n = 1'b1;
        repeat (2) @(posedge clk);
        for (c = 0; c < num_cases; c++)
        begin
            run_case(c);
        end
        @(negedge clk);
        #1;

        total_errors = error_count + ring_writer_top_i.ring_writer_asserts_i.fail_count;
        $display("cases: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
                 num_cases, failed_cases, error_count,
                 ring_writer_top_i.ring_writer_asserts_i.fail_count);
        if (total_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/ring_pkg.sv
rtl/line_fifo.sv
rtl/idle_timer.sv
rtl/flush_fsm.sv
rtl/write_req_gen.sv
rtl/ring_writer_top.sv
test/ring_writer_asserts.sv
test/ring_writer_checker.sv
test/ring_writer_tb.sv

//--- test/ring_writer_cases.txt
// line count, gap between lines, host consume period (0 holds the host until
// the ring fills), enable pattern (one bit per 16 cycles), first data seed
// All fields in hex, one case per line, a case with no lines ends the list
00000001 00000000 00000001 ffffffff 00001234
00000010 00000000 00000001 ffffffff 0000a5a5
00000028 00000003 00000002 ffffffff 13572468
00000050 00000000 00000000 ffffffff 0badcafe
00000030 00000001 00000003 f0f0f0f0 00c0ffee
00000020 00000014 00000001 ffffffff 7777aaaa
00000044 00000000 00000005 55555555 31415926
00000040 00000002 00000000 ffffffff 27182818
00000018 00000000 00000001 fffffffe 5eed0001
00000011 00000011 00000004 ffff00ff 600df00d
00000060 00000000 00000002 ffffffff 42424242
00000000 00000000 00000000 00000000 00000000
